/* source/rvPipe_macros.svh */
`ifndef RVPIPE_MACROS_SVH
`define RVPIPE_MACROS_SVH

// datapath widths
`define XLEN       32
`define REG_ADDR_W 5

// memory depths in words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

`define RESET_PC 32'h0000_0000
`define INST_NOP 32'h0000_0013 // addi x0, x0, 0

// RV32I major opcodes
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_SYSTEM 7'b1110011

`endif

/* source/rvPipePkg.sv */
`include "rvPipe_macros.svh"

package rvPipePkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REG_ADDR_W-1:0] regAddr_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } aluOp_t;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSel_t;

  // operand source in execute
  typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwdSel_t;

  typedef struct packed {
    logic       valid;
    word_t      pc;
    word_t      rs1Data;
    word_t      rs2Data;
    word_t      imm;
    regAddr_t   rs1;
    regAddr_t   rs2;
    regAddr_t   rd;
    aluOp_t     aluOp;
    logic       aSel;        // 1 selects pc
    logic       bSel;        // 1 selects imm
    logic       isBranch;
    logic [2:0] branchFunct;
    logic       isJal;
    logic       isJalr;
    logic       memRead;
    logic       memWrite;
    logic       regWrite;
    wbSel_t     wbSel;
    logic       isEcall;
  } idExPayload_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    aluResult;
    word_t    storeData;
    regAddr_t rd;
    logic     memRead;
    logic     memWrite;
    logic     regWrite;
    wbSel_t   wbSel;
    logic     isEcall;
  } exMemPayload_t;

  typedef struct packed {
    logic     valid;
    regAddr_t rd;
    logic     regWrite;
    word_t    wbData;
    logic     isEcall;
  } memWbPayload_t;

endpackage

/* source/pipeReg.sv */
`timescale 1ns/1ps

module pipeReg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     en,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // an all-zero payload is a bubble with valid low
  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;
    end else if (en) begin
      q <= flush ? '0 : d;
    end
  end

endmodule

/* source/fetchStage.sv */
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module fetchStage (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               imemWe,
  input  logic [$clog2(`IMEM_DEPTH)-1:0]     imemAddr,
  input  rvPipePkg::word_t                   imemData,
  input  logic                               stall,
  input  logic                               redirect,
  input  rvPipePkg::word_t                   redirectPc,
  input  logic                               halted,
  output rvPipePkg::word_t                   ifPc,
  output rvPipePkg::word_t                   ifInstr,
  output logic                               ifValid
);

  localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

  rvPipePkg::word_t imem [`IMEM_DEPTH];
  rvPipePkg::word_t pc;
  logic             advance;

  assign advance = !halted && !redirect && !stall;

  // program load port is only live in reset
  always_ff @(posedge clk) begin
    if (rst && imemWe) begin
      imem[imemAddr] <= imemData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= `RESET_PC;
      ifValid <= 1'b0;
    end else if (!halted) begin
      if (redirect) begin
        pc      <= redirectPc;
        ifValid <= 1'b0; // kill the younger fetch
      end else if (!stall) begin
        pc      <= pc + 32'd4;
        ifValid <= 1'b1;
      end
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (rst || (!halted && redirect)) begin
      ifInstr <= `INST_NOP;
    end else if (advance) begin
      ifPc    <= pc;
      ifInstr <= imem[pc[IMEM_AW+1:2]];
    end
  end

  assert property (@(posedge clk) imemWe |-> rst)
    else $error("instruction memory write outside reset");

endmodule

/* source/decodeStage.sv */
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module decodeStage (
  input  rvPipePkg::word_t        ifPc,
  input  rvPipePkg::word_t        ifInstr,
  input  logic                    ifValid,
  input  rvPipePkg::word_t        rs1Data,
  input  rvPipePkg::word_t        rs2Data,
  input  rvPipePkg::regAddr_t     exRd,
  input  logic                    exMemRead,
  input  logic                    redirect,
  output rvPipePkg::regAddr_t     rs1,
  output rvPipePkg::regAddr_t     rs2,
  output logic                    stall,
  output logic                    bubble,
  output rvPipePkg::idExPayload_t idEx
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  rvPipePkg::regAddr_t     rd;
  rvPipePkg::word_t        immI;
  rvPipePkg::word_t        immS;
  rvPipePkg::word_t        immB;
  rvPipePkg::word_t        immU;
  rvPipePkg::word_t        immJ;
  logic                    altOp;
  logic                    usesRs1;
  logic                    usesRs2;
  logic                    writesRd;
  rvPipePkg::aluOp_t       fnOp;
  rvPipePkg::idExPayload_t ctl;

  assign opcode = ifInstr[6:0];
  assign funct3 = ifInstr[14:12];
  assign rd     = ifInstr[11:7];

  ////////////////////////////////////////////////////////////////////////////
  // immediates
  assign immI = {{20{ifInstr[31]}}, ifInstr[31:20]};
  assign immS = {{20{ifInstr[31]}}, ifInstr[31:25], ifInstr[11:7]};
  assign immB = {{19{ifInstr[31]}}, ifInstr[31], ifInstr[7], ifInstr[30:25],
                 ifInstr[11:8], 1'b0};
  assign immU = {ifInstr[31:12], 12'b0};
  assign immJ = {{11{ifInstr[31]}}, ifInstr[31], ifInstr[19:12], ifInstr[20],
                 ifInstr[30:21], 1'b0};

  // bit 30 means sub/sra, but only shifts use it on op-imm
  assign altOp = ifInstr[30] && (opcode == `OPC_OP || funct3 == 3'b101);

  always_comb begin
    case (funct3)
      3'b000:  fnOp = altOp ? rvPipePkg::ALU_SUB : rvPipePkg::ALU_ADD;
      3'b001:  fnOp = rvPipePkg::ALU_SLL;
      3'b010:  fnOp = rvPipePkg::ALU_SLT;
      3'b011:  fnOp = rvPipePkg::ALU_SLTU;
      3'b100:  fnOp = rvPipePkg::ALU_XOR;
      3'b101:  fnOp = altOp ? rvPipePkg::ALU_SRA : rvPipePkg::ALU_SRL;
      3'b110:  fnOp = rvPipePkg::ALU_OR;
      default: fnOp = rvPipePkg::ALU_AND;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // control decode with unknown opcodes left all zero
  always_comb begin
    ctl      = '0;
    usesRs1  = 1'b0;
    usesRs2  = 1'b0;
    writesRd = 1'b0;
    case (opcode)
      `OPC_OP: begin
        usesRs1   = 1'b1;
        usesRs2   = 1'b1;
        writesRd  = 1'b1;
        ctl.aluOp = fnOp;
      end
      `OPC_OP_IMM: begin
        usesRs1   = 1'b1;
        writesRd  = 1'b1;
        ctl.aluOp = fnOp;
        ctl.bSel  = 1'b1;
        ctl.imm   = immI;
      end
      `OPC_LUI, `OPC_AUIPC: begin
        writesRd = 1'b1;
        ctl.aSel = (opcode == `OPC_AUIPC); // lui adds to x0
        ctl.bSel = 1'b1;
        ctl.imm  = immU;
      end
      `OPC_LOAD: begin
        usesRs1     = (funct3 == 3'b010); // word only
        writesRd    = usesRs1;
        ctl.memRead = usesRs1;
        ctl.bSel    = 1'b1;
        ctl.imm     = immI;
        ctl.wbSel   = rvPipePkg::WB_MEM;
      end
      `OPC_STORE: begin
        usesRs1      = (funct3 == 3'b010);
        usesRs2      = usesRs1;
        ctl.memWrite = usesRs1;
        ctl.bSel     = 1'b1;
        ctl.imm      = immS;
      end
      `OPC_BRANCH: begin
        usesRs1      = 1'b1;
        usesRs2      = 1'b1;
        ctl.isBranch = 1'b1;
        ctl.imm      = immB;
      end
      `OPC_JAL: begin
        writesRd  = 1'b1;
        ctl.isJal = 1'b1;
        ctl.imm   = immJ;
        ctl.wbSel = rvPipePkg::WB_PC4;
      end
      `OPC_JALR: begin
        usesRs1    = 1'b1;
        writesRd   = 1'b1;
        ctl.isJalr = 1'b1;
        ctl.imm    = immI;
        ctl.wbSel  = rvPipePkg::WB_PC4;
      end
      `OPC_SYSTEM: ctl.isEcall = (ifInstr[31:7] == '0);
      default: ;
    endcase
  end

  // unused source fields read as x0
  assign rs1 = usesRs1 ? ifInstr[19:15] : '0;
  assign rs2 = usesRs2 ? ifInstr[24:20] : '0;

  always_comb begin
    idEx             = ctl;
    idEx.valid       = ifValid;
    idEx.pc          = ifPc;
    idEx.rs1         = rs1;
    idEx.rs2         = rs2;
    idEx.rd          = rd;
    idEx.rs1Data     = rs1Data;
    idEx.rs2Data     = rs2Data;
    idEx.branchFunct = funct3;
    idEx.regWrite    = writesRd && (rd != '0);
  end

  // load-use hazard where x0 never matches
  assign stall  = ifValid && exMemRead && (exRd != '0) && (rs1 == exRd || rs2 == exRd);
  assign bubble = stall || redirect;

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic                clk,
  input  logic                rst,
  input  rvPipePkg::regAddr_t rs1,
  input  rvPipePkg::regAddr_t rs2,
  output rvPipePkg::word_t    rs1Data,
  output rvPipePkg::word_t    rs2Data,
  input  logic                we,
  input  rvPipePkg::regAddr_t rd,
  input  rvPipePkg::word_t    wd
);

  rvPipePkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wd;
    end
  end

  // same-cycle write shows through to decode
  function automatic rvPipePkg::word_t readPort(input rvPipePkg::regAddr_t ra);
    if (we && rd != '0 && ra == rd) return wd;
    return regs[ra];
  endfunction

  assign rs1Data = readPort(rs1);
  assign rs2Data = readPort(rs2);

  // x0 is held at zero by reset and the write gate
  assert property (@(posedge clk) disable iff (rst) (rs1 == '0) |-> (rs1Data == '0))
    else $error("x0 read back nonzero on rs1");

  assert property (@(posedge clk) disable iff (rst) (rs2 == '0) |-> (rs2Data == '0))
    else $error("x0 read back nonzero on rs2");

endmodule

/* source/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
  input  rvPipePkg::idExPayload_t  idEx,
  input  rvPipePkg::regAddr_t      memFwdRd,
  input  logic                     memFwdValid,
  input  rvPipePkg::word_t         memFwdData,
  input  rvPipePkg::regAddr_t      wbFwdRd,
  input  logic                     wbFwdValid,
  input  rvPipePkg::word_t         wbFwdData,
  output logic                     redirect,
  output rvPipePkg::word_t         redirectPc,
  output rvPipePkg::exMemPayload_t exMem
);

  rvPipePkg::fwdSel_t fwdA;
  rvPipePkg::fwdSel_t fwdB;
  rvPipePkg::word_t   rs1Val;
  rvPipePkg::word_t   rs2Val;
  rvPipePkg::word_t   aluA;
  rvPipePkg::word_t   aluB;
  rvPipePkg::word_t   aluOut;
  rvPipePkg::word_t   jalrSum;
  logic               cond;

  // EX/MEM is younger than MEM/WB, so it wins
  function automatic rvPipePkg::fwdSel_t pickSrc(input rvPipePkg::regAddr_t rs);
    if (memFwdValid && memFwdRd == rs) return rvPipePkg::FWD_MEM;
    if (wbFwdValid && wbFwdRd == rs) return rvPipePkg::FWD_WB;
    return rvPipePkg::FWD_REG;
  endfunction

  assign fwdA = pickSrc(idEx.rs1);
  assign fwdB = pickSrc(idEx.rs2);

  assign rs1Val = (fwdA == rvPipePkg::FWD_MEM) ? memFwdData :
                  (fwdA == rvPipePkg::FWD_WB)  ? wbFwdData  : idEx.rs1Data;
  assign rs2Val = (fwdB == rvPipePkg::FWD_MEM) ? memFwdData :
                  (fwdB == rvPipePkg::FWD_WB)  ? wbFwdData  : idEx.rs2Data;

  assign aluA = idEx.aSel ? idEx.pc : rs1Val;
  assign aluB = idEx.bSel ? idEx.imm : rs2Val;

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  always_comb begin
    case (idEx.aluOp)
      rvPipePkg::ALU_SUB:  aluOut = aluA - aluB;
      rvPipePkg::ALU_SLL:  aluOut = aluA << aluB[4:0];
      rvPipePkg::ALU_SLT:  aluOut = rvPipePkg::word_t'($signed(aluA) < $signed(aluB));
      rvPipePkg::ALU_SLTU: aluOut = rvPipePkg::word_t'(aluA < aluB);
      rvPipePkg::ALU_XOR:  aluOut = aluA ^ aluB;
      rvPipePkg::ALU_SRL:  aluOut = aluA >> aluB[4:0];
      rvPipePkg::ALU_SRA:  aluOut = $signed(aluA) >>> aluB[4:0];
      rvPipePkg::ALU_OR:   aluOut = aluA | aluB;
      rvPipePkg::ALU_AND:  aluOut = aluA & aluB;
      default:             aluOut = aluA + aluB;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // branch compare and redirect
  always_comb begin
    case (idEx.branchFunct)
      3'b000:  cond = (rs1Val == rs2Val);
      3'b001:  cond = (rs1Val != rs2Val);
      3'b100:  cond = ($signed(rs1Val) < $signed(rs2Val));
      3'b101:  cond = ($signed(rs1Val) >= $signed(rs2Val));
      3'b110:  cond = (rs1Val < rs2Val);
      3'b111:  cond = (rs1Val >= rs2Val);
      default: cond = 1'b0;
    endcase
  end

  // bubbles carry no control bits
  assign redirect = (idEx.isBranch && cond) || idEx.isJal || idEx.isJalr;

  assign jalrSum    = rs1Val + idEx.imm;
  assign redirectPc = idEx.isJalr ? (jalrSum & ~rvPipePkg::word_t'(1)) : idEx.pc + idEx.imm;

  always_comb begin
    exMem.valid     = idEx.valid;
    exMem.pc        = idEx.pc;
    exMem.aluResult = aluOut;
    exMem.storeData = rs2Val; // forwarded store data
    exMem.rd        = idEx.rd;
    exMem.memRead   = idEx.memRead;
    exMem.memWrite  = idEx.memWrite;
    exMem.regWrite  = idEx.regWrite;
    exMem.wbSel     = idEx.wbSel;
    exMem.isEcall   = idEx.isEcall;
  end

endmodule

/* source/memStage.sv */
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module memStage (
  input  logic                     clk,
  input  rvPipePkg::exMemPayload_t exMem,
  output rvPipePkg::memWbPayload_t memWb
);

  localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

  rvPipePkg::word_t   dmem [`DMEM_DEPTH];
  logic [DMEM_AW-1:0] wordIdx;
  rvPipePkg::word_t   readData;

  assign wordIdx = exMem.aluResult[DMEM_AW+1:2]; // word addressed

  always_ff @(posedge clk) begin
    if (exMem.valid && exMem.memWrite) begin
      dmem[wordIdx] <= exMem.storeData;
    end
  end

  assign readData = exMem.memRead ? dmem[wordIdx] : '0;

  always_comb begin
    memWb.valid    = exMem.valid;
    memWb.rd       = exMem.rd;
    memWb.regWrite = exMem.regWrite;
    memWb.isEcall  = exMem.isEcall;
    case (exMem.wbSel)
      rvPipePkg::WB_MEM: memWb.wbData = readData;
      rvPipePkg::WB_PC4: memWb.wbData = exMem.pc + 32'd4; // link address
      default:           memWb.wbData = exMem.aluResult;
    endcase
  end

  assert property (@(posedge clk)
    (exMem.valid && (exMem.memRead || exMem.memWrite)) |-> (exMem.aluResult[1:0] == 2'b00))
    else $error("misaligned data access");

endmodule

/* source/rvPipeTop.sv */
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module rvPipeTop (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           imemWe,
  input  logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr,
  input  rvPipePkg::word_t               imemData,
  output logic                           wbValid,
  output rvPipePkg::regAddr_t            wbRd,
  output rvPipePkg::word_t               wbData,
  output logic                           halted
);

  rvPipePkg::word_t         ifPc;
  rvPipePkg::word_t         ifInstr;
  logic                     ifValid;
  rvPipePkg::regAddr_t      rs1;
  rvPipePkg::regAddr_t      rs2;
  rvPipePkg::word_t         rs1Data;
  rvPipePkg::word_t         rs2Data;
  logic                     stall;
  logic                     bubble;
  logic                     redirect;
  rvPipePkg::word_t         redirectPc;
  rvPipePkg::idExPayload_t  idExD;
  rvPipePkg::idExPayload_t  idExQ;
  rvPipePkg::exMemPayload_t exMemD;
  rvPipePkg::exMemPayload_t exMemQ;
  rvPipePkg::exMemPayload_t exMemLive;
  rvPipePkg::memWbPayload_t memWbD;
  rvPipePkg::memWbPayload_t memWbQ;
  rvPipePkg::word_t         memFwdData;
  logic                     haltReg;
  logic                     ecallInWb;

  ////////////////////////////////////////////////////////////////////////////
  // halt freezes every stage once ecall reaches write-back
  assign ecallInWb = memWbQ.valid && memWbQ.isEcall;
  assign halted    = haltReg || ecallInWb;

  always_ff @(posedge clk) begin
    if (rst) begin
      haltReg <= 1'b0;
    end else if (ecallInWb) begin
      haltReg <= 1'b1;
    end
  end

  // no stores from instructions behind the ecall
  always_comb begin
    exMemLive       = exMemQ;
    exMemLive.valid = exMemQ.valid && !halted;
  end

  // jal/jalr results are the link address, not the ALU sum
  assign memFwdData = (exMemQ.wbSel == rvPipePkg::WB_PC4) ? exMemQ.pc + 32'd4
                                                          : exMemQ.aluResult;

  assign wbValid = memWbQ.valid && memWbQ.regWrite;
  assign wbRd    = memWbQ.rd;
  assign wbData  = memWbQ.wbData;

  ////////////////////////////////////////////////////////////////////////////
  // stages
  fetchStage fetchStage_i (
    .clk(clk), .rst(rst), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
    .stall(stall), .redirect(redirect), .redirectPc(redirectPc), .halted(halted),
    .ifPc(ifPc), .ifInstr(ifInstr), .ifValid(ifValid)
  );

  decodeStage decodeStage_i (
    .ifPc(ifPc), .ifInstr(ifInstr), .ifValid(ifValid),
    .rs1Data(rs1Data), .rs2Data(rs2Data),
    .exRd(idExQ.rd), .exMemRead(idExQ.memRead), .redirect(redirect),
    .rs1(rs1), .rs2(rs2), .stall(stall), .bubble(bubble), .idEx(idExD)
  );

  regFile regFile_i (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rs1Data(rs1Data), .rs2Data(rs2Data),
    .we(wbValid), .rd(memWbQ.rd), .wd(memWbQ.wbData)
  );

  pipeReg #(.payload_t(rvPipePkg::idExPayload_t)) idExReg_i (
    .clk(clk), .rst(rst), .en(!halted), .flush(bubble), .d(idExD), .q(idExQ)
  );

  executeStage executeStage_i (
    .idEx(idExQ),
    .memFwdRd(exMemQ.rd), .memFwdValid(exMemQ.valid && exMemQ.regWrite),
    .memFwdData(memFwdData),
    .wbFwdRd(memWbQ.rd), .wbFwdValid(wbValid), .wbFwdData(memWbQ.wbData),
    .redirect(redirect), .redirectPc(redirectPc), .exMem(exMemD)
  );

  pipeReg #(.payload_t(rvPipePkg::exMemPayload_t)) exMemReg_i (
    .clk(clk), .rst(rst), .en(!halted), .flush(1'b0), .d(exMemD), .q(exMemQ)
  );

  memStage memStage_i (
    .clk(clk), .exMem(exMemLive), .memWb(memWbD)
  );

  pipeReg #(.payload_t(rvPipePkg::memWbPayload_t)) memWbReg_i (
    .clk(clk), .rst(rst), .en(!halted), .flush(1'b0), .d(memWbD), .q(memWbQ)
  );

  // stall is raised by decode but only a live load in ID/EX justifies it
  assert property (@(posedge clk) disable iff (rst) stall |-> (idExQ.valid && idExQ.memRead))
    else $error("load-use stall without a load in ID/EX");

  assert property (@(posedge clk) disable iff (rst) redirect |-> idExQ.valid)
    else $error("redirect from a bubble");

endmodule

/* verification/clkGen.sv */
`timescale 1ns/1ps

module clkGen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 5,
  parameter int DRIVE_DLY  = 2
) (
  input  logic loadDone,
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // rst covers the program load, then RST_CYCLES more edges
  initial begin
    rst = 1'b1;
    wait (loadDone === 1'b1);
    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY) rst = 1'b0; // same skew as the other inputs
  end

endmodule

/* verification/rvPipeTb.sv */
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module rvPipeTb;

  localparam int    CLK_PERIOD  = 20;
  localparam int    RST_CYCLES  = 5;
  localparam int    DRIVE_DLY   = 2;
  localparam int    CYC_PER_WORD = 40;
  localparam int    IDLE_CYCLES = 10;
  localparam int    IMEM_AW     = $clog2(`IMEM_DEPTH);
  localparam string DATA_FILE   = "verification/rvPipe_testdata.txt";

  logic                clk;
  logic                rst;
  logic                loadDone;
  logic                imemWe;
  logic [IMEM_AW-1:0]  imemAddr;
  rvPipePkg::word_t    imemData;
  logic                wbValid;
  rvPipePkg::regAddr_t wbRd;
  rvPipePkg::word_t    wbData;
  logic                halted;

  rvPipePkg::word_t    progWords [$];
  rvPipePkg::regAddr_t expRd [$];
  rvPipePkg::word_t    expVal [$];

  int checkErrors = 0; // owned by the write-back monitor
  int flowErrors  = 0; // owned by the main sequence
  int wbCount     = 0;
  bit haltSeen    = 1'b0;

  clkGen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES), .DRIVE_DLY(DRIVE_DLY)) clkGen_i (
    .loadDone(loadDone), .clk(clk), .rst(rst)
  );

  rvPipeTop rvPipeTop_i (
    .clk(clk), .rst(rst), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
    .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData), .halted(halted)
  );

  ////////////////////////////////////////////////////////////////////////////
  // test data and program load

  // hex words up to the -- line, then "rd value" records
  task automatic readTestData(output bit ok);
    int               fd;
    int               n;
    int               rd;
    string            line;
    bit               inExpect;
    rvPipePkg::word_t word;
    ok       = 1'b0;
    inExpect = 1'b0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0 || line.getc(0) == "#") continue;
      if (line.getc(0) == "-") begin
        inExpect = 1'b1;
      end else if (!inExpect && $sscanf(line, "%h", word) == 1) begin
        progWords.push_back(word);
      end else if (inExpect && $sscanf(line, "%d %h", rd, word) == 2) begin
        expRd.push_back(rvPipePkg::regAddr_t'(rd));
        expVal.push_back(word);
      end
    end
    $fclose(fd);
    ok = progWords.size() > 0 && progWords.size() <= `IMEM_DEPTH && expRd.size() > 0;
  endtask

  task automatic loadProgram();
    foreach (progWords[i]) begin
      @(posedge clk);
      #(DRIVE_DLY);
      imemWe   = 1'b1;
      imemAddr = IMEM_AW'(i);
      imemData = progWords[i];
    end
    @(posedge clk);
    #(DRIVE_DLY);
    imemWe   = 1'b0;
    loadDone = 1'b1; // lets clkGen count out the reset
  endtask

  task automatic printSummary();
    $display("summary: %0d write-back errors, %0d run errors, %0d of %0d write-backs seen",
             checkErrors, flowErrors, wbCount, expRd.size());
  endtask

  task automatic stopOnFailure(input string why);
    $display("%s", why);
    printSummary();
    $display(">>> FAIL");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // write-back monitor sampling mid-cycle

  task automatic checkWriteBack();
    assert (wbCount < expRd.size()) else begin
      checkErrors++;
      $display("unexpected extra write-back to x%0d at %0t ns", wbRd, $time);
    end
    if (wbCount < expRd.size()) begin
      assert (wbRd == expRd[wbCount] && wbData == expVal[wbCount]) else begin
        checkErrors++;
        $display("CHECK FAILED at %0t ns: write-back %0d gave x%0d = %h, expected x%0d = %h",
                 $time, wbCount, wbRd, wbData, expRd[wbCount], expVal[wbCount]);
      end
    end
    wbCount++;
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      if (wbValid) begin
        checkWriteBack();
      end
      assert (halted || !haltSeen) else begin
        checkErrors++;
        $display("halted fell at %0t ns without a reset", $time);
      end
      if (halted) begin
        haltSeen = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial begin : mainFlow
    bit fileOk;
    imemWe   = 1'b0;
    imemAddr = '0;
    imemData = '0;
    loadDone = 1'b0;
    readTestData(fileOk);
    if (!fileOk) begin
      stopOnFailure("the test data file could not be read or holds no usable data");
    end else begin
      loadProgram();
      @(negedge rst);
      @(negedge clk);
      assert (!wbValid && !halted) else begin
        flowErrors++;
        $display("wbValid or halted is high right after reset");
      end
      wait (halted === 1'b1);
      repeat (IDLE_CYCLES) @(posedge clk); // nothing may retire past the ecall
      assert (wbCount == expRd.size()) else begin
        flowErrors++;
        $display("saw %0d write-backs but the test data expects %0d", wbCount, expRd.size());
      end
      printSummary();
      if (checkErrors == 0 && flowErrors == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

  initial begin : watchdog
    wait (loadDone === 1'b1);
    #(progWords.size() * CYC_PER_WORD * CLK_PERIOD);
    stopOnFailure("timeout: the pipeline never halted within the cycle budget");
  end

endmodule

/* rvPipe.f */
+incdir+source
source/rvPipePkg.sv
source/pipeReg.sv
source/fetchStage.sv
source/decodeStage.sv
source/regFile.sv
source/executeStage.sv
source/memStage.sv
source/rvPipeTop.sv
verification/clkGen.sv
verification/rvPipeTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the rvPipe testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f rvPipe.f --top-module rvPipeTb \
  || { echo "build failed"; exit 1; }
./obj_dir/VrvPipeTb > "$LOG" 2>&1
cat "$LOG"
grep -q ">>> FAIL" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" "$LOG" || { echo "no result found in $LOG"; exit 1; }
echo "simulation passed"

/* verification/rvPipe_testdata.txt */
# program words in hex, one per line from address 0
# after the -- line each record is rd (decimal) and the expected value (hex)
00500093  # 00 addi x1, x0, 5
ffd00113  # 04 addi x2, x0, -3
002081b3  # 08 add  x3, x1, x2
40118233  # 0c sub  x4, x3, x1
123452b7  # 10 lui  x5, 0x12345
00001317  # 14 auipc x6, 0x1
00411393  # 18 slli x7, x2, 4
40115413  # 1c srai x8, x2, 1
01c15493  # 20 srli x9, x2, 28
00112533  # 24 slt  x10, x2, x1
001135b3  # 28 sltu x11, x2, x1
0ff0c613  # 2c xori x12, x1, 0xff
0012e6b3  # 30 or   x13, x5, x1
0066f733  # 34 and  x14, x13, x6
00502423  # 38 sw   x5, 8(x0)
00802783  # 3c lw   x15, 8(x0)
00178813  # 40 addi x16, x15, 1
00108663  # 44 beq  x1, x1, +12
00100893  # 48 addi x17, x0, 1
00200893  # 4c addi x17, x0, 2
00c0096f  # 50 jal  x18, +12
00100993  # 54 addi x19, x0, 1
00200993  # 58 addi x19, x0, 2
07000a13  # 5c addi x20, x0, 0x70
000a0ae7  # 60 jalr x21, 0(x20)
00100b13  # 64 addi x22, x0, 1
00200b13  # 68 addi x22, x0, 2
00300b13  # 6c addi x22, x0, 3
00109463  # 70 bne  x1, x1, +8
00700b93  # 74 addi x23, x0, 7
00000073  # 78 ecall
00000013  # 7c nop
00000013  # 80 nop
00000013  # 84 nop
-- expected write-backs
1  00000005
2  fffffffd
3  00000002
4  fffffffd
5  12345000
6  00001014
7  ffffffd0
8  fffffffe
9  0000000f
10 00000001
11 00000000
12 000000fa
13 12345005
14 00001004
15 12345000
16 12345001
18 00000054
20 00000070
21 00000064
23 00000007
